// ==== verilog/decode_pkg.sv ====
// Opcode constants, register number type, instruction word union, prefix word struct and helpers
package decode_pkg;

	// ======================================================================
	// Basic types
	// ======================================================================

	// Architectural register number; register zero always reads as zero
	typedef logic [6:0] aregno_t;
	typedef logic [6:0] opcode_t;

	// Width of the immediate handed to the rename stage
	localparam int IMM_WIDTH = 64;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Register form ALU operations
	localparam opcode_t OP_ADD   = 7'h04;
	localparam opcode_t OP_SUB   = 7'h05;
	localparam opcode_t OP_AND   = 7'h08;
	localparam opcode_t OP_OR    = 7'h09;
	// Immediate form ALU operations and CSR access
	localparam opcode_t OP_CSR   = 7'h07;
	localparam opcode_t OP_ADDI  = 7'h14;
	localparam opcode_t OP_ANDI  = 7'h18;
	localparam opcode_t OP_ORI   = 7'h19;
	localparam opcode_t OP_CMPI  = 7'h1b;
	// Memory, branch and stack operations
	localparam opcode_t OP_BCC   = 7'h28;
	localparam opcode_t OP_LOAD  = 7'h48;
	localparam opcode_t OP_STORE = 7'h50;
	localparam opcode_t OP_PUSH  = 7'h58;
	localparam opcode_t OP_POP   = 7'h59;
	// Register extension prefix, found in the word after the instruction
	localparam opcode_t OP_REXT  = 7'h7d;

	// ======================================================================
	// Instruction formats
	// ======================================================================

	// Register form; the upper bits hold a branch displacement for OP_BCC
	typedef struct packed {
		logic [22:0] disp;
		logic [5:0]  rs2;
		logic [5:0]  rs1;
		logic [5:0]  rd;
		opcode_t     opcode;
	} r_form_t;

	// Immediate form; everything above rs1 is a single immediate
	typedef struct packed {
		logic [28:0] imm;
		logic [5:0]  rs1;
		logic [5:0]  rd;
		opcode_t     opcode;
	} i_form_t;

	// Both views cover the same 48 bit word
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} instr_t;

	// Prefix word; each x field is a full width register number
	typedef struct packed {
		logic [19:0] rsvd;
		aregno_t     rdx;
		aregno_t     rs2x;
		aregno_t     rs1x;
		opcode_t     opcode;
	} rext_t;

	// The following word is a prefix when it carries the REXT opcode
	function automatic logic is_prefix(input rext_t pfx);
		return pfx.opcode == OP_REXT;
	endfunction

	// Pick the prefix field when present, else widen the short field
	function automatic aregno_t widen_reg(input logic has_rext, input aregno_t xfield,
		input logic [5:0] field);
		if (has_rext)
			return xfield;
		return {1'b0, field};
	endfunction

endpackage

// ==== verilog/decode_rs1.sv ====
// Source register A decoder with prefix widening and immediate A override
`timescale 1ns/1ps

module decode_rs1
	import decode_pkg::*;
(
	input  instr_t      instr,
	input  logic [47:0] next_raw,
	input  logic        has_imma,
	output aregno_t     rs1,
	output logic        rs1z
);

	// The following word viewed as a possible prefix
	rext_t pfx;
	logic  has_rext;

	assign pfx      = rext_t'(next_raw);
	assign has_rext = is_prefix(pfx);

	always_comb
	begin
		// A separate immediate takes the place of operand A
		if (has_imma)
			rs1 = '0;
		else
		begin
			case (instr.r_form.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR:
				rs1 = widen_reg(has_rext, pfx.rs1x, instr.r_form.rs1);
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_CSR:
				rs1 = widen_reg(has_rext, pfx.rs1x, instr.i_form.rs1);
			// Loads and stores use rs1 as the base address
			OP_LOAD, OP_STORE:
				rs1 = widen_reg(has_rext, pfx.rs1x, instr.i_form.rs1);
			OP_BCC:
				rs1 = widen_reg(has_rext, pfx.rs1x, instr.r_form.rs1);
			// Stack operations address through the implied stack pointer
			default:
				rs1 = '0;
			endcase
		end
	end

	// Flag reads of the zero register so rename can skip the lookup
	assign rs1z = ~|rs1;

endmodule

// ==== verilog/decode_rs2.sv ====
// Source register B decoder with opcode dependent field position and prefix widening
`timescale 1ns/1ps

module decode_rs2
	import decode_pkg::*;
(
	input  instr_t      instr,
	input  logic [47:0] next_raw,
	output aregno_t     rs2,
	output logic        rs2z
);

	// The following word viewed as a possible prefix
	rext_t pfx;
	logic  has_rext;

	assign pfx      = rext_t'(next_raw);
	assign has_rext = is_prefix(pfx);

	always_comb
	begin
		case (instr.r_form.opcode)
		// Register ALU and compare-and-branch read the normal rs2 field
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_BCC:
			rs2 = widen_reg(has_rext, pfx.rs2x, instr.r_form.rs2);
		// Store and push carry their data register in the rd position
		// The prefix still extends it through rs2x, since it is read as rs2
		OP_STORE, OP_PUSH:
			rs2 = widen_reg(has_rext, pfx.rs2x, instr.r_form.rd);
		// Immediate forms have no second register operand
		default:
			rs2 = '0;
		endcase
	end

	assign rs2z = ~|rs2;

endmodule

// ==== verilog/decode_rd.sv ====
// Destination register decoder that suppresses rd for stores, branches and pushes
`timescale 1ns/1ps

module decode_rd
	import decode_pkg::*;
(
	input  instr_t      instr,
	input  logic [47:0] next_raw,
	output aregno_t     rd,
	output logic        rdz
);

	// The following word viewed as a possible prefix
	rext_t pfx;
	logic  has_rext;

	assign pfx      = rext_t'(next_raw);
	assign has_rext = is_prefix(pfx);

	always_comb
	begin
		case (instr.r_form.opcode)
		OP_ADD, OP_SUB, OP_AND, OP_OR:
			rd = widen_reg(has_rext, pfx.rdx, instr.r_form.rd);
		OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_CSR, OP_LOAD:
			rd = widen_reg(has_rext, pfx.rdx, instr.i_form.rd);
		// Pop writes the popped value back to a register
		OP_POP:
			rd = widen_reg(has_rext, pfx.rdx, instr.r_form.rd);
		// Stores, branches and pushes write no register
		// For those the rd field is either data or unused
		default:
			rd = '0;
		endcase
	end

	// A zero destination means the result is discarded
	assign rdz = ~|rd;

endmodule

// ==== verilog/decode_imm.sv ====
// Immediate extractor and sign extender, with the illegal opcode detector
`timescale 1ns/1ps

module decode_imm
	import decode_pkg::*;
(
	input  instr_t                 instr,
	output logic [IMM_WIDTH-1:0]   imm,
	output logic                   imm_valid,
	output logic                   illegal
);

	// The two raw immediate fields, both topped by bit 47 of the word
	logic [28:0] imm_i;
	logic [22:0] disp_b;

	assign imm_i  = instr.i_form.imm;
	assign disp_b = instr.r_form.disp;

	always_comb
	begin
		imm       = '0;
		imm_valid = 1'b0;
		illegal   = 1'b0;
		case (instr.r_form.opcode)
		// Register forms and stack operations carry no immediate
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_PUSH, OP_POP:
			imm_valid = 1'b0;
		// Immediate ALU, CSR number and memory offset all use the i form field
		OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_CSR, OP_LOAD, OP_STORE:
		begin
			imm       = {{(IMM_WIDTH-29){imm_i[28]}}, imm_i};
			imm_valid = 1'b1;
		end
		// Branches read the displacement through the r form view
		OP_BCC:
		begin
			imm       = {{(IMM_WIDTH-23){disp_b[22]}}, disp_b};
			imm_valid = 1'b1;
		end
		// A stray prefix is known, just not executable, so it is not flagged
		OP_REXT:
			imm_valid = 1'b0;
		default:
			illegal = 1'b1;
		endcase
	end

endmodule

// ==== verilog/decode_stage.sv ====
// Register field decode stage top level with one registered output bank
`timescale 1ns/1ps

module decode_stage
	import decode_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  logic [47:0]          instr,
	input  logic [47:0]          next_raw,
	input  logic                 has_imma,
	output logic                 out_valid,
	output aregno_t              rs1,
	output logic                 rs1z,
	output aregno_t              rs2,
	output logic                 rs2z,
	output aregno_t              rd,
	output logic                 rdz,
	output logic [IMM_WIDTH-1:0] imm,
	output logic                 imm_valid,
	output logic                 illegal
);

	// ======================================================================
	// Combinational decode
	// ======================================================================

	// One view of the incoming word shared by all four decoders
	instr_t instr_word;

	// Decoder results ahead of the output register
	aregno_t              rs1_d;
	aregno_t              rs2_d;
	aregno_t              rd_d;
	logic                 rs1z_d;
	logic                 rs2z_d;
	logic                 rdz_d;
	logic [IMM_WIDTH-1:0] imm_d;
	logic                 imm_valid_d;
	logic                 illegal_d;

	assign instr_word = instr_t'(instr);

	decode_rs1 u_rs1 (
		.instr    (instr_word),
		.next_raw (next_raw),
		.has_imma (has_imma),
		.rs1      (rs1_d),
		.rs1z     (rs1z_d)
	);

	decode_rs2 u_rs2 (
		.instr    (instr_word),
		.next_raw (next_raw),
		.rs2      (rs2_d),
		.rs2z     (rs2z_d)
	);

	decode_rd u_rd (
		.instr    (instr_word),
		.next_raw (next_raw),
		.rd       (rd_d),
		.rdz      (rdz_d)
	);

	decode_imm u_imm (
		.instr     (instr_word),
		.imm       (imm_d),
		.imm_valid (imm_valid_d),
		.illegal   (illegal_d)
	);

	// ======================================================================
	// Output register
	// ======================================================================

	// Fields load only with a valid word and hold otherwise
	// so rename sees stable values while out_valid is low
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			rs1       <= '0;
			rs1z      <= 1'b0;
			rs2       <= '0;
			rs2z      <= 1'b0;
			rd        <= '0;
			rdz       <= 1'b0;
			imm       <= '0;
			imm_valid <= 1'b0;
			illegal   <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
			begin
				rs1       <= rs1_d;
				rs1z      <= rs1z_d;
				rs2       <= rs2_d;
				rs2z      <= rs2z_d;
				rd        <= rd_d;
				rdz       <= rdz_d;
				imm       <= imm_d;
				imm_valid <= imm_valid_d;
				illegal   <= illegal_d;
			end
		end
	end

endmodule

// ==== test/tb_decode_stage.sv ====
// Testbench for the decode stage with random stimulus, a reference model, checks and a watchdog
`timescale 1ns/1ps

module tb_decode_stage
	import decode_pkg::*;
();

	typedef struct packed {
		logic [6:0]  rs1;
		logic        rs1z;
		logic [6:0]  rs2;
		logic        rs2z;
		logic [6:0]  rd;
		logic        rdz;
		logic [63:0] imm;
		logic        imm_valid;
		logic        illegal;
	} result_t;

	logic clk, reset, in_valid, has_imma, out_valid;
	logic [47:0] instr, next_raw;
	logic [6:0] rs1, rs2, rd;
	logic rs1z, rs2z, rdz, imm_valid, illegal;
	logic [63:0] imm;

	integer seed;
	string test_name;
	int mismatches = 0;
	int tests_failed = 0;
	int basic_count = 200;
	int stream_count = 500;
	result_t expect_q[$];
	opcode_t legal_ops [15] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_ANDI, OP_ORI,
		OP_CMPI, OP_CSR, OP_LOAD, OP_STORE, OP_BCC, OP_PUSH, OP_POP, OP_REXT};

	decode_stage u_decode_stage (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Expected outputs straight from the opcode table
	function automatic result_t model_decode(input logic [47:0] word, input logic [47:0] follow,
		input logic imma);
		result_t r;
		logic [6:0] op;
		logic pfx, ralu, ialu, ld, st, bcc, push, pop;
		op   = word[6:0];
		pfx  = follow[6:0] == OP_REXT;
		ralu = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR};
		ialu = op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_CSR};
		ld   = op == OP_LOAD;
		st   = op == OP_STORE;
		bcc  = op == OP_BCC;
		push = op == OP_PUSH;
		pop  = op == OP_POP;
		r = '0;
		if ((ralu || ialu || ld || st || bcc) && !imma)
			r.rs1 = pfx ? follow[13:7] : {1'b0, word[18:13]};
		// Store and push read their data register from the rd position
		if (ralu || bcc)
			r.rs2 = pfx ? follow[20:14] : {1'b0, word[24:19]};
		else if (st || push)
			r.rs2 = pfx ? follow[20:14] : {1'b0, word[12:7]};
		if (ralu || ialu || ld || pop)
			r.rd = pfx ? follow[27:21] : {1'b0, word[12:7]};
		r.rs1z = r.rs1 == 7'd0;
		r.rs2z = r.rs2 == 7'd0;
		r.rdz  = r.rd == 7'd0;
		if (ialu || ld || st)
			r.imm = {{35{word[47]}}, word[47:19]};
		else if (bcc)
			r.imm = {{41{word[47]}}, word[47:25]};
		r.imm_valid = ialu || ld || st || bcc;
		r.illegal   = !(ralu || ialu || ld || st || bcc || push || pop || op == OP_REXT);
		return r;
	endfunction

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, field, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_output(input logic valid_exp, input result_t e);
		check_value("out_valid", 64'(valid_exp), 64'(out_valid));
		check_value("rs1", 64'(e.rs1), 64'(rs1));
		check_value("rs1z", 64'(e.rs1z), 64'(rs1z));
		check_value("rs2", 64'(e.rs2), 64'(rs2));
		check_value("rs2z", 64'(e.rs2z), 64'(rs2z));
		check_value("rd", 64'(e.rd), 64'(rd));
		check_value("rdz", 64'(e.rdz), 64'(rdz));
		check_value("imm", e.imm, imm);
		check_value("imm_valid", 64'(e.imm_valid), 64'(imm_valid));
		check_value("illegal", 64'(e.illegal), 64'(illegal));
	endtask

	// Rates of 0 mean never, 1 always and N one time in N
	task automatic make_word(input int prefix_rate, input int imma_mode, input int odd_rate,
		output logic [47:0] word, output logic [47:0] follow, output logic imma);
		logic [31:0] r0, r1;
		int pick;
		r0 = $random(seed);
		r1 = $random(seed);
		pick = $random(seed) & 32'h7fffffff;
		word = {r1[15:0], r0};
		if (odd_rate == 0 || (pick % odd_rate) != 0)
			word[6:0] = legal_ops[4'(pick % 15)];
		r0 = $random(seed);
		r1 = $random(seed);
		follow = {r0[15:0], r1};
		pick = $random(seed) & 32'h7fffffff;
		if (prefix_rate != 0 && (pick % prefix_rate) == 0)
			follow[6:0] = OP_REXT;
		else if (follow[6:0] == OP_REXT)
			follow[6:0] = OP_ADD;
		imma = (imma_mode == 2) ? r1[31] : (imma_mode == 1);
	endtask

	// Streams words back to back, then checks one idle cycle where the fields hold
	task automatic run_stream(input string name, input int count, input int prefix_rate,
		input int imma_mode, input int odd_rate);
		logic [47:0] word, follow;
		logic imma;
		int errs_before;
		result_t last;
		test_name = name;
		errs_before = mismatches;
		for (int i = 0; i < count; i++)
		begin
			make_word(prefix_rate, imma_mode, odd_rate, word, follow, imma);
			@(posedge clk);
			in_valid <= 1'b1;
			instr    <= word;
			next_raw <= follow;
			has_imma <= imma;
			@(negedge clk);
			if (expect_q.size() > 0)
				check_output(1'b1, expect_q.pop_front());
			expect_q.push_back(model_decode(word, follow, imma));
		end
		// A fresh word during the idle cycle shows whether the fields really hold
		make_word(prefix_rate, imma_mode, odd_rate, word, follow, imma);
		@(posedge clk);
		in_valid <= 1'b0;
		instr    <= word;
		next_raw <= follow;
		has_imma <= imma;
		@(negedge clk);
		last = expect_q.pop_front();
		check_output(1'b1, last);
		@(negedge clk);
		check_output(1'b0, last);
		report_test(name, count, mismatches - errs_before);
	endtask

	task automatic report_test(input string name, input int count, input int errs);
		$display("%-18s %4d vectors, %0d mismatches, %s", name, count, errs,
			(errs == 0) ? "passed" : "FAILED");
		if (errs != 0)
			tests_failed++;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial
	begin
		seed     = 32'hd5c024fd;
		reset    = 1'b1;
		in_valid = 1'b0;
		instr    = '0;
		next_raw = '0;
		has_imma = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		test_name = "reset_state";
		check_output(1'b0, '0);
		report_test(test_name, 0, mismatches);
		run_stream("single_pulse", 1, 3, 0, 8);
		run_stream("unprefixed_regs", basic_count, 0, 0, 8);
		run_stream("prefixed_regs", basic_count, 1, 0, 8);
		run_stream("imm_a_override", basic_count, 3, 1, 8);
		run_stream("immediates", basic_count, 3, 2, 2);
		run_stream("back_to_back", stream_count, 3, 2, 8);
		$display("Summary: 7 tests, %0d failed, %0d mismatches", tests_failed, mismatches);
		if (mismatches == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Every vector takes one cycle, plus reset, two idle cycles per test and a margin
	initial
	begin : watchdog
		int limit;
		limit = (4 + 1 + 4 * basic_count + stream_count + 7 * 2 + 100) * 40;
		#(limit);
		$display("Timeout: the tests did not finish within %0d ns", limit);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/decode_pkg.sv
verilog/decode_rs1.sv
verilog/decode_rs2.sv
verilog/decode_rd.sv
verilog/decode_imm.sv
verilog/decode_stage.sv
test/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_decode_stage
RTL_TOP    ?= decode_stage
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
